//--- cce_cache_defines.svh
// power-of-two sets and words, at least 2 ways; the window is one line index plus a line offset
`ifndef CCE_CACHE_DEFINES_SVH
`define CCE_CACHE_DEFINES_SVH

`define DWORD_WIDTH 64
`define BLOCK_WORDS 4
`define BLOCK_WIDTH (`DWORD_WIDTH * `BLOCK_WORDS)
`define PADDR_WIDTH 32

`define CACHE_SETS 16
`define CACHE_WAYS 2
`define CACHE_ADDR_WIDTH 10

`define META_DEPTH 4

// derived index widths
`define SET_IDX_WIDTH $clog2(`CACHE_SETS)
`define WAY_IDX_WIDTH $clog2(`CACHE_WAYS)
`define LINE_IDX_WIDTH ($clog2(`CACHE_SETS) + $clog2(`CACHE_WAYS))
`define LINE_OFF_WIDTH $clog2(`BLOCK_WIDTH / 8)
`define WORD_OFF_WIDTH $clog2(`DWORD_WIDTH / 8)

`endif

//--- cce_cache_pkg.sv
// cache_addr_u views have equal widths only while the window matches the defines
`include "cce_cache_defines.svh"

package cce_cache_pkg;

  typedef enum logic [2:0] {
    e_mem_rd    = 3'd0,
    e_mem_wr    = 3'd1,
    e_mem_uc_rd = 3'd2,
    e_mem_uc_wr = 3'd3,
    e_mem_wb    = 3'd4
  } mem_msg_e;

  // log2 of the byte count
  typedef enum logic [2:0] {
    e_size_1  = 3'd0,
    e_size_2  = 3'd1,
    e_size_4  = 3'd2,
    e_size_8  = 3'd3,
    e_size_16 = 3'd4,
    e_size_32 = 3'd5
  } mem_size_e;

  typedef enum logic [3:0] {
    e_op_tagst,
    e_op_lb,
    e_op_lh,
    e_op_lw,
    e_op_lm,
    e_op_sb,
    e_op_sh,
    e_op_sw,
    e_op_sm
  } cache_op_e;

  // byte view for loads and stores, way/set view for tag-store packets
  typedef union packed {
    struct packed {
      logic [`LINE_IDX_WIDTH-1:0] line;
      logic [`LINE_OFF_WIDTH-1:0] offset;
    } byte_addr;
    struct packed {
      logic [`WAY_IDX_WIDTH-1:0]  way;
      logic [`SET_IDX_WIDTH-1:0]  set;
      logic [`LINE_OFF_WIDTH-1:0] unused;
    } tag_addr;
  } cache_addr_u;

endpackage

//--- cce_cache_top.sv
// commands are refused until the post-reset tag clear of every line has finished
`timescale 1ns/100ps
`include "cce_cache_defines.svh"

module cce_cache_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  cce_cache_pkg::mem_msg_e  mem_cmd_type_i,
  input  cce_cache_pkg::mem_size_e mem_cmd_size_i,
  input  logic [`PADDR_WIDTH-1:0]  mem_cmd_addr_i,
  input  logic [`BLOCK_WIDTH-1:0]  mem_cmd_data_i,
  input  logic                     mem_cmd_v_i,
  output logic                     mem_cmd_yumi_o,
  output cce_cache_pkg::mem_msg_e  mem_resp_type_o,
  output cce_cache_pkg::mem_size_e mem_resp_size_o,
  output logic [`PADDR_WIDTH-1:0]  mem_resp_addr_o,
  output logic [`BLOCK_WIDTH-1:0]  mem_resp_data_o,
  output logic                     mem_resp_v_o,
  input  logic                     mem_resp_ready_i
);

  cce_cache_pkg::cache_op_e   pkt_op;
  cce_cache_pkg::cache_addr_u pkt_addr;
  logic [`DWORD_WIDTH-1:0]    pkt_data, rsp_data;
  logic                       pkt_v, pkt_ready, rsp_v, rsp_yumi;

  cce_to_cache_adapter adapter (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .mem_cmd_type_i  (mem_cmd_type_i),
    .mem_cmd_size_i  (mem_cmd_size_i),
    .mem_cmd_addr_i  (mem_cmd_addr_i),
    .mem_cmd_data_i  (mem_cmd_data_i),
    .mem_cmd_v_i     (mem_cmd_v_i),
    .mem_cmd_yumi_o  (mem_cmd_yumi_o),
    .mem_resp_type_o (mem_resp_type_o),
    .mem_resp_size_o (mem_resp_size_o),
    .mem_resp_addr_o (mem_resp_addr_o),
    .mem_resp_data_o (mem_resp_data_o),
    .mem_resp_v_o    (mem_resp_v_o),
    .mem_resp_ready_i(mem_resp_ready_i),
    .pkt_op_o        (pkt_op),
    .pkt_addr_o      (pkt_addr),
    .pkt_data_o      (pkt_data),
    .pkt_v_o         (pkt_v),
    .pkt_ready_i     (pkt_ready),
    .rsp_data_i      (rsp_data),
    .rsp_v_i         (rsp_v),
    .rsp_yumi_o      (rsp_yumi)
  );

  line_store cache (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .pkt_op_i   (pkt_op),
    .pkt_addr_i (pkt_addr),
    .pkt_data_i (pkt_data),
    .pkt_v_i    (pkt_v),
    .pkt_ready_o(pkt_ready),
    .rsp_data_o (rsp_data),
    .rsp_v_o    (rsp_v),
    .rsp_yumi_i (rsp_yumi)
  );

endmodule

//--- cce_to_cache_adapter.sv
// command inputs must stay stable until mem_cmd_yumi_o; rd and wb always move a whole block
`timescale 1ns/100ps
`include "cce_cache_defines.svh"

module cce_to_cache_adapter (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  cce_cache_pkg::mem_msg_e      mem_cmd_type_i,
  input  cce_cache_pkg::mem_size_e     mem_cmd_size_i,
  input  logic [`PADDR_WIDTH-1:0]      mem_cmd_addr_i,
  input  logic [`BLOCK_WIDTH-1:0]      mem_cmd_data_i,
  input  logic                         mem_cmd_v_i,
  output logic                         mem_cmd_yumi_o,
  output cce_cache_pkg::mem_msg_e      mem_resp_type_o,
  output cce_cache_pkg::mem_size_e     mem_resp_size_o,
  output logic [`PADDR_WIDTH-1:0]      mem_resp_addr_o,
  output logic [`BLOCK_WIDTH-1:0]      mem_resp_data_o,
  output logic                         mem_resp_v_o,
  input  logic                         mem_resp_ready_i,
  output cce_cache_pkg::cache_op_e     pkt_op_o,
  output cce_cache_pkg::cache_addr_u   pkt_addr_o,
  output logic [`DWORD_WIDTH-1:0]      pkt_data_o,
  output logic                         pkt_v_o,
  input  logic                         pkt_ready_i,
  input  logic [`DWORD_WIDTH-1:0]      rsp_data_i,
  input  logic                         rsp_v_i,
  output logic                         rsp_yumi_o
);

  localparam int cnt_w     = $clog2(`BLOCK_WORDS);
  localparam int lines     = `CACHE_SETS * `CACHE_WAYS;
  localparam int tag_cnt_w = $clog2(lines + 1);
  localparam int msg_w     = $bits(cce_cache_pkg::mem_msg_e);
  localparam int size_w    = $bits(cce_cache_pkg::mem_size_e);
  localparam int hdr_w     = msg_w + size_w + `PADDR_WIDTH;

  localparam logic [1:0] cmd_reset = 2'd0;
  localparam logic [1:0] cmd_clear = 2'd1;
  localparam logic [1:0] cmd_ready = 2'd2;
  localparam logic [1:0] cmd_send  = 2'd3;

  localparam logic [1:0] resp_reset   = 2'd0;
  localparam logic [1:0] resp_ready   = 2'd1;
  localparam logic [1:0] resp_receive = 2'd2;
  localparam logic [1:0] resp_send    = 2'd3;

  // index of the last word a command moves
  function automatic logic [cnt_w-1:0] last_word(cce_cache_pkg::mem_msg_e t,
                                                 cce_cache_pkg::mem_size_e s);
    logic [cnt_w-1:0] n;
    if (t == cce_cache_pkg::e_mem_rd || t == cce_cache_pkg::e_mem_wb) begin
      n = cnt_w'(`BLOCK_WORDS - 1);
    end else begin
      case (s)
        cce_cache_pkg::e_size_16: n = cnt_w'(1);
        cce_cache_pkg::e_size_32: n = cnt_w'(`BLOCK_WORDS - 1);
        default:                  n = '0;
      endcase
    end
    return n;
  endfunction

  function automatic cce_cache_pkg::cache_op_e cache_op(cce_cache_pkg::mem_msg_e t,
                                                        cce_cache_pkg::mem_size_e s);
    logic st;
    cce_cache_pkg::cache_op_e op;
    st = (t == cce_cache_pkg::e_mem_uc_wr) || (t == cce_cache_pkg::e_mem_wb);
    case (s)
      cce_cache_pkg::e_size_1: op = st ? cce_cache_pkg::e_op_sb : cce_cache_pkg::e_op_lb;
      cce_cache_pkg::e_size_2: op = st ? cce_cache_pkg::e_op_sh : cce_cache_pkg::e_op_lh;
      cce_cache_pkg::e_size_4: op = st ? cce_cache_pkg::e_op_sw : cce_cache_pkg::e_op_lw;
      default:                 op = st ? cce_cache_pkg::e_op_sm : cce_cache_pkg::e_op_lm;
    endcase
    return op;
  endfunction

  logic [1:0] cmd_state_r, cmd_state_n, resp_state_r, resp_state_n;
  logic [tag_cnt_w-1:0] tag_sent_r, tag_sent_n, tag_rcvd_r, tag_rcvd_n;
  logic [cnt_w-1:0] cmd_cnt_r, cmd_cnt_n, cmd_last_r, cmd_last_n;
  logic [cnt_w-1:0] resp_cnt_r, resp_cnt_n, resp_last_r, resp_last_n;
  logic [`BLOCK_WORDS-1:0][`DWORD_WIDTH-1:0] cmd_words, resp_block_r;
  logic [`CACHE_ADDR_WIDTH-1:0] word_off;
  logic fifo_v_li, fifo_ready_lo, fifo_v_lo, fifo_yumi_li;
  logic [hdr_w-1:0] hdr_lo;

  assign cmd_words = mem_cmd_data_i;
  assign word_off  = {{(`CACHE_ADDR_WIDTH - cnt_w - `WORD_OFF_WIDTH){1'b0}}, cmd_cnt_r,
                      {`WORD_OFF_WIDTH{1'b0}}};

  cmd_meta_fifo #(
    .width_p(hdr_w),
    .depth_p(`META_DEPTH)
  ) meta_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (fifo_v_li),
    .data_i ({mem_cmd_type_i, mem_cmd_size_i, mem_cmd_addr_i}),
    .ready_o(fifo_ready_lo),
    .v_o    (fifo_v_lo),
    .data_o (hdr_lo),
    .yumi_i (fifo_yumi_li)
  );

  // header stays at the queue head until its response is taken
  assign mem_resp_type_o = cce_cache_pkg::mem_msg_e'(hdr_lo[hdr_w-1 -: msg_w]);
  assign mem_resp_size_o = cce_cache_pkg::mem_size_e'(hdr_lo[`PADDR_WIDTH +: size_w]);
  assign mem_resp_addr_o = hdr_lo[`PADDR_WIDTH-1:0];
  assign mem_resp_data_o = resp_block_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cmd_state_r  <= cmd_reset;
      tag_sent_r   <= '0;
      tag_rcvd_r   <= '0;
      cmd_cnt_r    <= '0;
      cmd_last_r   <= '0;
      resp_state_r <= resp_reset;
      resp_cnt_r   <= '0;
      resp_last_r  <= '0;
    end else begin
      cmd_state_r  <= cmd_state_n;
      tag_sent_r   <= tag_sent_n;
      tag_rcvd_r   <= tag_rcvd_n;
      cmd_cnt_r    <= cmd_cnt_n;
      cmd_last_r   <= cmd_last_n;
      resp_state_r <= resp_state_n;
      resp_cnt_r   <= resp_cnt_n;
      resp_last_r  <= resp_last_n;
    end
  end

  always_comb begin
    cmd_state_n    = cmd_state_r;
    tag_sent_n     = tag_sent_r;
    tag_rcvd_n     = tag_rcvd_r;
    cmd_cnt_n      = cmd_cnt_r;
    cmd_last_n     = cmd_last_r;
    pkt_v_o        = 1'b0;
    pkt_op_o       = cce_cache_pkg::e_op_tagst;
    pkt_addr_o     = '0;
    pkt_data_o     = '0;
    mem_cmd_yumi_o = 1'b0;
    fifo_v_li      = 1'b0;
    case (cmd_state_r)
      cmd_reset: cmd_state_n = cmd_clear;
      cmd_clear: begin
        pkt_v_o = (tag_sent_r != tag_cnt_w'(lines));
        pkt_addr_o.tag_addr.way = tag_sent_r[`SET_IDX_WIDTH +: `WAY_IDX_WIDTH];
        pkt_addr_o.tag_addr.set = tag_sent_r[`SET_IDX_WIDTH-1:0];
        if (pkt_v_o & pkt_ready_i) begin
          tag_sent_n = tag_sent_r + 1'b1;
        end
        if (rsp_v_i & rsp_yumi_o) begin
          tag_rcvd_n = tag_rcvd_r + 1'b1;
        end
        if (tag_sent_r == tag_cnt_w'(lines) && tag_rcvd_r == tag_cnt_w'(lines)) begin
          cmd_state_n = cmd_ready;
        end
      end
      cmd_ready: begin
        fifo_v_li = mem_cmd_v_i;
        if (mem_cmd_v_i & fifo_ready_lo) begin
          cmd_last_n  = last_word(mem_cmd_type_i, mem_cmd_size_i);
          cmd_state_n = cmd_send;
        end
      end
      default: begin
        pkt_v_o    = 1'b1;
        pkt_op_o   = cache_op(mem_cmd_type_i, mem_cmd_size_i);
        pkt_addr_o = mem_cmd_addr_i[`CACHE_ADDR_WIDTH-1:0] + word_off;
        pkt_data_o = cmd_words[cmd_cnt_r];
        if (pkt_ready_i) begin
          cmd_cnt_n = cmd_cnt_r + 1'b1;
          if (cmd_cnt_r == cmd_last_r) begin
            mem_cmd_yumi_o = 1'b1;
            cmd_cnt_n      = '0;
            cmd_state_n    = cmd_ready;
          end
        end
      end
    endcase
  end

  always_comb begin
    resp_state_n = resp_state_r;
    resp_cnt_n   = resp_cnt_r;
    resp_last_n  = resp_last_r;
    rsp_yumi_o   = 1'b0;
    mem_resp_v_o = 1'b0;
    fifo_yumi_li = 1'b0;
    case (resp_state_r)
      resp_reset: resp_state_n = resp_ready;
      resp_ready: begin
        if (fifo_v_lo) begin
          resp_last_n  = last_word(mem_resp_type_o, mem_resp_size_o);
          resp_state_n = resp_receive;
        end else begin
          // nothing queued, so drop the reply
          rsp_yumi_o = rsp_v_i;
        end
      end
      resp_receive: begin
        if (rsp_v_i) begin
          rsp_yumi_o = 1'b1;
          resp_cnt_n = resp_cnt_r + 1'b1;
          if (resp_cnt_r == resp_last_r) begin
            resp_cnt_n   = '0;
            resp_state_n = resp_send;
          end
        end
      end
      default: begin
        mem_resp_v_o = 1'b1;
        if (mem_resp_ready_i) begin
          fifo_yumi_li = 1'b1;
          resp_state_n = resp_ready;
        end
      end
    endcase
  end

  // unused words of a short response read as zero
  always_ff @(posedge clk_i) begin
    if (resp_state_r == resp_ready && fifo_v_lo) begin
      resp_block_r <= '0;
    end else if (resp_state_r == resp_receive && rsp_v_i) begin
      resp_block_r[resp_cnt_r] <= rsp_data_i;
    end
  end

endmodule

//--- cmd_meta_fifo.sv
// yumi_i must only be raised while v_o is high; depth_p of 2 or more
`timescale 1ns/100ps

module cmd_meta_fifo #(
  parameter int width_p = 8,
  parameter int depth_p = 4
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               v_i,
  input  logic [width_p-1:0] data_i,
  output logic               ready_o,
  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  localparam int ptr_w = $clog2(depth_p);

  logic [width_p-1:0] mem_r [depth_p];
  logic [ptr_w-1:0] rd_ptr_r, wr_ptr_r, rd_ptr_nxt, wr_ptr_nxt;
  logic full_r, empty_r;
  logic enq, deq;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rd_ptr_r];
  assign enq     = v_i & ~full_r;
  assign deq     = yumi_i;

  // pointers wrap at depth_p, which need not be a power of two
  assign rd_ptr_nxt = (rd_ptr_r == ptr_w'(depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
  assign wr_ptr_nxt = (wr_ptr_r == ptr_w'(depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end else begin
      if (enq) begin
        wr_ptr_r <= wr_ptr_nxt;
      end
      if (deq) begin
        rd_ptr_r <= rd_ptr_nxt;
      end
      if (enq & ~deq) begin
        empty_r <= 1'b0;
        full_r  <= (wr_ptr_nxt == rd_ptr_r);
      end else if (deq & ~enq) begin
        full_r  <= 1'b0;
        empty_r <= (rd_ptr_nxt == wr_ptr_r);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

//--- line_store.sv
// window over low address bits with no miss path; invalid lines read zero; aligned accesses only
`timescale 1ns/100ps
`include "cce_cache_defines.svh"

module line_store (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  cce_cache_pkg::cache_op_e   pkt_op_i,
  input  cce_cache_pkg::cache_addr_u pkt_addr_i,
  input  logic [`DWORD_WIDTH-1:0]    pkt_data_i,
  input  logic                       pkt_v_i,
  output logic                       pkt_ready_o,
  output logic [`DWORD_WIDTH-1:0]    rsp_data_o,
  output logic                       rsp_v_o,
  input  logic                       rsp_yumi_i
);

  localparam int lines  = `CACHE_SETS * `CACHE_WAYS;
  localparam int nbytes = `DWORD_WIDTH / 8;
  localparam int word_w = $clog2(`BLOCK_WORDS);

  logic [`DWORD_WIDTH-1:0] mem_r [lines][`BLOCK_WORDS];
  logic [lines-1:0] valid_r;
  logic [`DWORD_WIDTH-1:0] rsp_data_r;
  logic rsp_v_r;

  logic accept, is_store, is_tagst;
  logic [`LINE_IDX_WIDTH-1:0] line, tag_line;
  logic [word_w-1:0] word_idx;
  logic [`WORD_OFF_WIDTH-1:0] byte_idx;
  logic [`DWORD_WIDTH-1:0] stored, shifted, load_data, store_word, bit_mask;
  logic [nbytes-1:0] byte_mask;

  assign pkt_ready_o = ~rsp_v_r | rsp_yumi_i;
  assign accept      = pkt_v_i & pkt_ready_o;
  assign rsp_v_o     = rsp_v_r;
  assign rsp_data_o  = rsp_data_r;

  assign line     = pkt_addr_i.byte_addr.line;
  assign word_idx = pkt_addr_i.byte_addr.offset[`WORD_OFF_WIDTH +: word_w];
  assign byte_idx = pkt_addr_i.byte_addr.offset[`WORD_OFF_WIDTH-1:0];
  assign tag_line = {pkt_addr_i.tag_addr.way, pkt_addr_i.tag_addr.set};
  assign is_tagst = (pkt_op_i == cce_cache_pkg::e_op_tagst);

  assign stored  = valid_r[line] ? mem_r[line][word_idx] : '0;
  assign shifted = stored >> {byte_idx, 3'b000};

  always_comb begin
    load_data = '0;
    byte_mask = '0;
    is_store  = 1'b0;
    case (pkt_op_i)
      cce_cache_pkg::e_op_lb: load_data[7:0]  = shifted[7:0];
      cce_cache_pkg::e_op_lh: load_data[15:0] = shifted[15:0];
      cce_cache_pkg::e_op_lw: load_data[31:0] = shifted[31:0];
      cce_cache_pkg::e_op_lm: load_data       = stored;
      cce_cache_pkg::e_op_sb: begin
        is_store  = 1'b1;
        byte_mask = nbytes'(1) << byte_idx;
      end
      cce_cache_pkg::e_op_sh: begin
        is_store  = 1'b1;
        byte_mask = nbytes'(3) << byte_idx;
      end
      cce_cache_pkg::e_op_sw: begin
        is_store  = 1'b1;
        byte_mask = nbytes'(15) << byte_idx;
      end
      cce_cache_pkg::e_op_sm: begin
        is_store  = 1'b1;
        byte_mask = '1;
      end
      default: load_data = '0;
    endcase
  end

  always_comb begin
    for (int i = 0; i < nbytes; i++) begin
      bit_mask[i*8 +: 8] = {8{byte_mask[i]}};
    end
  end

  // store data arrives in the low lanes
  assign store_word = (stored & ~bit_mask) | ((pkt_data_i << {byte_idx, 3'b000}) & bit_mask);

  always_ff @(posedge clk_i) begin
    if (accept & is_store) begin
      for (int w = 0; w < `BLOCK_WORDS; w++) begin
        if (word_idx == word_w'(w)) begin
          mem_r[line][w] <= store_word;
        end else if (!valid_r[line]) begin
          mem_r[line][w] <= '0;
        end
      end
    end
  end

  // tag-store invalidates and any store validates
  always_ff @(posedge clk_i) begin
    if (accept & is_tagst) begin
      valid_r[tag_line] <= 1'b0;
    end else if (accept & is_store) begin
      valid_r[line] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_data_r <= load_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_v_r <= 1'b0;
    end else if (accept) begin
      rsp_v_r <= 1'b1;
    end else if (rsp_yumi_i) begin
      rsp_v_r <= 1'b0;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_cce_cache -f src.f
out=$(./obj_dir/Vtb_cce_cache +verilator+error+limit+100 2>&1) || true
echo "$out"
echo "$out" | grep -qxF '** PASS **'

//--- src.f
+incdir+.
cce_cache_pkg.sv
cmd_meta_fifo.sv
cce_to_cache_adapter.sv
line_store.sv
cce_cache_top.sv
tb_cce_cache_chk.sv
tb_cce_cache.sv

//--- tb_cce_cache.sv
// expected data assumes a full tag clear after reset and aligned accesses inside the 1 KB window
`timescale 1ns/100ps
`include "cce_cache_defines.svh"

module tb_cce_cache;

  localparam int timeout_cycles = 200;
  localparam int aw = `CACHE_ADDR_WIDTH;
  localparam int window_bytes = 1 << `CACHE_ADDR_WIDTH;

  logic clk_i;
  logic reset_i;
  cce_cache_pkg::mem_msg_e mem_cmd_type_i, mem_resp_type_o;
  cce_cache_pkg::mem_size_e mem_cmd_size_i, mem_resp_size_o;
  logic [`PADDR_WIDTH-1:0] mem_cmd_addr_i, mem_resp_addr_o;
  logic [`BLOCK_WIDTH-1:0] mem_cmd_data_i, mem_resp_data_o;
  logic mem_cmd_v_i, mem_cmd_yumi_o, mem_resp_v_o, mem_resp_ready_i;

  // byte model of the cache window
  logic [7:0] ref_mem [window_bytes];
  logic [31:0] lfsr_r;
  int mismatches;
  int timeouts;

  cce_cache_top DUT (.*);

  bind cce_cache_top tb_cce_cache_chk chk (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_v_i     (mem_cmd_v_i),
    .cmd_yumi_i  (mem_cmd_yumi_o),
    .resp_v_i    (mem_resp_v_o),
    .resp_ready_i(mem_resp_ready_i),
    .resp_type_i (mem_resp_type_o),
    .resp_size_i (mem_resp_size_o),
    .resp_addr_i (mem_resp_addr_o),
    .resp_data_i (mem_resp_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [63:0] take_bits(int n);
    logic [63:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
      lfsr_r = {lfsr_r[30:0], fb};
      r = {r[62:0], fb};
    end
    return r;
  endfunction

  function automatic logic [`PADDR_WIDTH-1:0] rand_addr(int align);
    logic [63:0] r;
    r = take_bits(`PADDR_WIDTH);
    return (r[`PADDR_WIDTH-1:0] >> align) << align;
  endfunction

  function automatic logic [`BLOCK_WIDTH-1:0] rand_block();
    logic [`BLOCK_WIDTH-1:0] b;
    for (int w = 0; w < `BLOCK_WORDS; w++) begin
      b[w*`DWORD_WIDTH +: `DWORD_WIDTH] = take_bits(`DWORD_WIDTH);
    end
    return b;
  endfunction

  function automatic bit is_store(cce_cache_pkg::mem_msg_e t);
    return t == cce_cache_pkg::e_mem_uc_wr || t == cce_cache_pkg::e_mem_wb;
  endfunction

  // rd and wb move a whole block
  function automatic int msg_bytes(cce_cache_pkg::mem_msg_e t, cce_cache_pkg::mem_size_e s);
    if (t == cce_cache_pkg::e_mem_rd || t == cce_cache_pkg::e_mem_wb) begin
      return `BLOCK_WIDTH / 8;
    end
    return 1 << int'(s);
  endfunction

  function automatic logic [`BLOCK_WIDTH-1:0] expect_data(cce_cache_pkg::mem_msg_e t,
      cce_cache_pkg::mem_size_e s, logic [`PADDR_WIDTH-1:0] a);
    logic [`BLOCK_WIDTH-1:0] d;
    logic [aw-1:0] idx;
    d = '0;
    if (!is_store(t)) begin
      for (int i = 0; i < msg_bytes(t, s); i++) begin
        idx = a[aw-1:0] + i[aw-1:0];
        d[i*8 +: 8] = ref_mem[idx];
      end
    end
    return d;
  endfunction

  task automatic model_write(cce_cache_pkg::mem_msg_e t, cce_cache_pkg::mem_size_e s,
                             logic [`PADDR_WIDTH-1:0] a, logic [`BLOCK_WIDTH-1:0] data);
    logic [aw-1:0] idx;
    if (is_store(t)) begin
      for (int i = 0; i < msg_bytes(t, s); i++) begin
        idx = a[aw-1:0] + i[aw-1:0];
        ref_mem[idx] = data[i*8 +: 8];
      end
    end
  endtask

  task automatic cmp_block(string name, logic [`BLOCK_WIDTH-1:0] exp,
                           logic [`BLOCK_WIDTH-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic cmp_msg(string name, cce_cache_pkg::mem_msg_e exp,
                         cce_cache_pkg::mem_msg_e act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic cmp_size(string name, cce_cache_pkg::mem_size_e exp,
                          cce_cache_pkg::mem_size_e act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic cmp_addr(string name, logic [`PADDR_WIDTH-1:0] exp,
                          logic [`PADDR_WIDTH-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // held until yumi, sampled at the falling edge
  task automatic drive_cmd(string name, cce_cache_pkg::mem_msg_e t,
                           cce_cache_pkg::mem_size_e s, logic [`PADDR_WIDTH-1:0] a,
                           logic [`BLOCK_WIDTH-1:0] data);
    bit got;
    got = 1'b0;
    mem_cmd_type_i = t;
    mem_cmd_size_i = s;
    mem_cmd_addr_i = a;
    mem_cmd_data_i = data;
    mem_cmd_v_i    = 1'b1;
    for (int i = 0; i < timeout_cycles && !got; i++) begin
      @(negedge clk_i);
      got = mem_cmd_yumi_o;
    end
    if (!got) begin
      timeouts++;
      $display("%s: timed out waiting for the command to be taken", name);
    end
    @(posedge clk_i);
    #1;
    mem_cmd_v_i = 1'b0;
  endtask

  task automatic wait_resp_valid(string name, output bit got);
    got = 1'b0;
    for (int i = 0; i < timeout_cycles && !got; i++) begin
      @(negedge clk_i);
      got = mem_resp_v_o;
    end
    if (!got) begin
      timeouts++;
      $display("%s: timed out waiting for a response", name);
    end
  endtask

  task automatic collect_resp(string name, cce_cache_pkg::mem_msg_e t,
                              cce_cache_pkg::mem_size_e s, logic [`PADDR_WIDTH-1:0] a,
                              logic [`BLOCK_WIDTH-1:0] exp);
    bit got;
    mem_resp_ready_i = 1'b1;
    wait_resp_valid(name, got);
    if (got) begin
      cmp_msg(name, t, mem_resp_type_o);
      cmp_size(name, s, mem_resp_size_o);
      cmp_addr(name, a, mem_resp_addr_o);
      cmp_block(name, exp, mem_resp_data_o);
    end
    @(posedge clk_i);
    #1;
    mem_resp_ready_i = 1'b0;
  endtask

  task automatic run_cmd(string name, cce_cache_pkg::mem_msg_e t, cce_cache_pkg::mem_size_e s,
                         logic [`PADDR_WIDTH-1:0] a, logic [`BLOCK_WIDTH-1:0] data);
    logic [`BLOCK_WIDTH-1:0] exp;
    exp = expect_data(t, s, a);
    drive_cmd(name, t, s, a, data);
    model_write(t, s, a, data);
    collect_resp(name, t, s, a, exp);
  endtask

  task automatic test_reset_read();
    run_cmd("reset_rd", cce_cache_pkg::e_mem_rd, cce_cache_pkg::e_size_32, rand_addr(5), '0);
    run_cmd("reset_rd", cce_cache_pkg::e_mem_rd, cce_cache_pkg::e_size_32, rand_addr(5), '0);
  endtask

  task automatic test_block_write_read();
    logic [`PADDR_WIDTH-1:0] a;
    repeat (3) begin
      a = rand_addr(5);
      run_cmd("wb_block", cce_cache_pkg::e_mem_wb, cce_cache_pkg::e_size_32, a, rand_block());
      run_cmd("rd_block", cce_cache_pkg::e_mem_rd, cce_cache_pkg::e_size_32, a, '0);
    end
  endtask

  task automatic test_uc_narrow();
    cce_cache_pkg::mem_size_e sizes [4];
    logic [`PADDR_WIDTH-1:0] a;
    sizes = '{cce_cache_pkg::e_size_1, cce_cache_pkg::e_size_2, cce_cache_pkg::e_size_4,
              cce_cache_pkg::e_size_8};
    for (int k = 0; k < 4; k++) begin
      repeat (2) begin
        a = rand_addr(int'(sizes[k]));
        run_cmd("uc_wr_narrow", cce_cache_pkg::e_mem_uc_wr, sizes[k], a, rand_block());
        run_cmd("uc_rd_narrow", cce_cache_pkg::e_mem_uc_rd, sizes[k], a, '0);
        // neighbouring bytes of the block
        run_cmd("rd_around_narrow", cce_cache_pkg::e_mem_rd, cce_cache_pkg::e_size_32,
                (a >> 5) << 5, '0);
      end
    end
  endtask

  task automatic test_uc_wide();
    logic [`PADDR_WIDTH-1:0] a;
    a = rand_addr(4);
    run_cmd("uc_wr_16", cce_cache_pkg::e_mem_uc_wr, cce_cache_pkg::e_size_16, a, rand_block());
    run_cmd("uc_rd_16", cce_cache_pkg::e_mem_uc_rd, cce_cache_pkg::e_size_16, a, '0);
    a = rand_addr(5);
    run_cmd("uc_wr_32", cce_cache_pkg::e_mem_uc_wr, cce_cache_pkg::e_size_32, a, rand_block());
    run_cmd("uc_rd_32", cce_cache_pkg::e_mem_uc_rd, cce_cache_pkg::e_size_32, a, '0);
  endtask

  task automatic test_backpressure();
    logic [`PADDR_WIDTH-1:0] base;
    logic [`PADDR_WIDTH-1:0] addrs [3];
    cce_cache_pkg::mem_msg_e types [3];
    cce_cache_pkg::mem_size_e sizes [3];
    logic [`BLOCK_WIDTH-1:0] exps [3];
    bit got;
    base = rand_addr(5);
    run_cmd("bp_fill", cce_cache_pkg::e_mem_wb, cce_cache_pkg::e_size_32, base, rand_block());
    types = '{cce_cache_pkg::e_mem_rd, cce_cache_pkg::e_mem_uc_rd, cce_cache_pkg::e_mem_uc_rd};
    sizes = '{cce_cache_pkg::e_size_32, cce_cache_pkg::e_size_8, cce_cache_pkg::e_size_16};
    addrs = '{base, base + 32'd8, base + 32'd16};
    for (int i = 0; i < 3; i++) begin
      exps[i] = expect_data(types[i], sizes[i], addrs[i]);
    end
    mem_resp_ready_i = 1'b0;
    fork
      begin
        for (int i = 0; i < 3; i++) begin
          drive_cmd("backpressure", types[i], sizes[i], addrs[i], '0);
        end
      end
      begin
        wait_resp_valid("backpressure", got);
        // hold off while later commands queue up
        repeat (6) @(posedge clk_i);
        #1;
        for (int j = 0; j < 3; j++) begin
          collect_resp("backpressure", types[j], sizes[j], addrs[j], exps[j]);
        end
      end
    join
  endtask

  task automatic test_store_resp_zero();
    logic [`PADDR_WIDTH-1:0] a;
    a = rand_addr(5);
    run_cmd("st_zero_wb", cce_cache_pkg::e_mem_wb, cce_cache_pkg::e_size_32, a, rand_block());
    run_cmd("st_zero_uc", cce_cache_pkg::e_mem_uc_wr, cce_cache_pkg::e_size_8, a + 32'd8,
            rand_block());
    run_cmd("st_zero_rd", cce_cache_pkg::e_mem_rd, cce_cache_pkg::e_size_32, a, '0);
  endtask

  initial begin
    lfsr_r           = 32'h9cd45197;
    mismatches       = 0;
    timeouts         = 0;
    reset_i          = 1'b1;
    mem_cmd_type_i   = cce_cache_pkg::e_mem_rd;
    mem_cmd_size_i   = cce_cache_pkg::e_size_32;
    mem_cmd_addr_i   = '0;
    mem_cmd_data_i   = '0;
    mem_cmd_v_i      = 1'b0;
    mem_resp_ready_i = 1'b0;
    ref_mem          = '{default: 8'h00};
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    test_reset_read();
    test_block_write_read();
    test_uc_narrow();
    test_uc_wide();
    test_backpressure();
    test_store_resp_zero();
    $display("%0d mismatches, %0d timeouts, %0d assertion failures", mismatches, timeouts,
             DUT.chk.fail_count);
    if (mismatches + timeouts + DUT.chk.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- tb_cce_cache_chk.sv
// bound to cce_cache_top; the early-yumi check covers only the first command after each reset
`timescale 1ns/100ps
`include "cce_cache_defines.svh"

module tb_cce_cache_chk (
  input logic                     clk_i,
  input logic                     reset_i,
  input logic                     cmd_v_i,
  input logic                     cmd_yumi_i,
  input logic                     resp_v_i,
  input logic                     resp_ready_i,
  input cce_cache_pkg::mem_msg_e  resp_type_i,
  input cce_cache_pkg::mem_size_e resp_size_i,
  input logic [`PADDR_WIDTH-1:0]  resp_addr_i,
  input logic [`BLOCK_WIDTH-1:0]  resp_data_i
);

  // dead cycle plus one tag-store packet per line
  localparam logic [7:0] clear_cycles = 8'(`CACHE_SETS * `CACHE_WAYS + 1);

  logic [7:0] cycles_r;
  logic yumi_seen_r;
  int stable_fails;
  int yumi_fails;
  int early_fails;
  int fail_count;

  assign fail_count = stable_fails + yumi_fails + early_fails;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cycles_r    <= '0;
      yumi_seen_r <= 1'b0;
    end else begin
      if (cycles_r != '1) begin
        cycles_r <= cycles_r + 1'b1;
      end
      if (cmd_yumi_i) begin
        yumi_seen_r <= 1'b1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i && !resp_ready_i |=> resp_v_i && $stable(resp_type_i) && $stable(resp_size_i)
      && $stable(resp_addr_i) && $stable(resp_data_i))
    else begin
      stable_fails++;
      $error("response changed while stalled");
    end

  assert property (@(posedge clk_i) disable iff (reset_i) cmd_yumi_i |-> cmd_v_i)
    else begin
      yumi_fails++;
      $error("command yumi without a valid command");
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_yumi_i && !yumi_seen_r |-> cycles_r > clear_cycles)
    else begin
      early_fails++;
      $error("command taken before the tag clear finished");
    end

endmodule
